// File: rvfi_trace.f
+incdir+.
rv_isa_pkg.sv
trace_pkg.sv
retire_if.sv
retire_capture.sv
insn_decoder.sv
trace_buffer.sv
rvfi_trace_top.sv
rvfi_trace_assertions.sv
tb_rvfi_trace.sv

// File: tb_rvfi_trace.sv
/*
 * Retirement trace unit testbench
 * Directed tests that retire instructions and read the records over Wishbone
 */
`timescale 1ns/1ps
`include "trace_defines.svh"

module tb_rvfi_trace;

  // Tests use about 450 cycles, the limit leaves a wide margin
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] SEED           = 32'hd75876c2;

  localparam logic [6:0] OP_LUI    = 7'h37;
  localparam logic [6:0] OP_AUIPC  = 7'h17;
  localparam logic [6:0] OP_JAL    = 7'h6f;
  localparam logic [6:0] OP_JALR   = 7'h67;
  localparam logic [6:0] OP_BRANCH = 7'h63;
  localparam logic [6:0] OP_LOAD   = 7'h03;
  localparam logic [6:0] OP_STORE  = 7'h23;
  localparam logic [6:0] OP_IMM    = 7'h13;
  localparam logic [6:0] OP_REG    = 7'h33;
  localparam logic [6:0] OP_FENCE  = 7'h0f;
  localparam logic [6:0] OP_SYSTEM = 7'h73;
  // Custom-2 opcode, not part of RV32IM
  localparam logic [6:0] OP_CUSTOM = 7'h5b;

  localparam logic [3:0] C_LUI    = 4'd0;
  localparam logic [3:0] C_AUIPC  = 4'd1;
  localparam logic [3:0] C_JAL    = 4'd2;
  localparam logic [3:0] C_JALR   = 4'd3;
  localparam logic [3:0] C_BRANCH = 4'd4;
  localparam logic [3:0] C_LOAD   = 4'd5;
  localparam logic [3:0] C_STORE  = 4'd6;
  localparam logic [3:0] C_OP_IMM = 4'd7;
  localparam logic [3:0] C_OP     = 4'd8;
  localparam logic [3:0] C_MULDIV = 4'd9;
  localparam logic [3:0] C_CSR    = 4'd10;
  localparam logic [3:0] C_FENCE  = 4'd11;
  localparam logic [3:0] C_COMPR  = 4'd13;
  localparam logic [3:0] C_INVAL  = 4'd14;

  // Access mask bits
  localparam logic [3:0] A_RS1 = 4'b0001;
  localparam logic [3:0] A_RS2 = 4'b0010;
  localparam logic [3:0] A_RD  = 4'b0100;
  localparam logic [3:0] A_MEM = 4'b1000;

  logic        clk_i;
  logic        rst_ni;
  logic        rvfi_valid;
  logic [31:0] rvfi_insn;
  logic [31:0] rvfi_pc_rdata;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  int          cycles;
  int          err_count;
  int          tests_passed;
  int          tests_failed;
  logic [31:0] seed_word;

  rvfi_trace_top rvfi_trace_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rvfi_valid    (rvfi_valid),
    .rvfi_insn     (rvfi_insn),
    .rvfi_pc_rdata (rvfi_pc_rdata),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  // Instruction encoders, one per base format
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
      input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Error at time %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      err_count++;
    end
  endtask

  // Ack is sampled on the falling edge, where it is stable
  task automatic wait_ack();
    @(negedge clk_i);
    while (!wb_ack) begin
      @(negedge clk_i);
    end
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
    @(posedge clk_i);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack();
    data = wb_dat_r;
    @(posedge clk_i);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
    @(posedge clk_i);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack();
    @(posedge clk_i);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // One retirement, sampled on the second rising edge
  task automatic retire(input logic [31:0] insn, input logic [31:0] pc);
    @(posedge clk_i);
    #1;
    rvfi_valid    = 1'b1;
    rvfi_insn     = insn;
    rvfi_pc_rdata = pc;
    @(posedge clk_i);
    #1;
    rvfi_valid = 1'b0;
  endtask

  // Last record lands in the FIFO two edges after sampling
  task automatic wait_pipeline();
    @(posedge clk_i);
  endtask

  task automatic check_record(input string tag, input logic [31:0] pc,
      input logic [31:0] value, input logic [3:0] cls, input logic [3:0] acc,
      input logic [4:0] rd, output logic [15:0] stamp);
    logic [31:0] data;
    logic [31:0] info;
    info = (32'(cls) << `TRACE_INFO_CLASS_LSB) | (32'(acc) << `TRACE_INFO_ACCESS_LSB) |
           (32'(rd) << `TRACE_INFO_RD_LSB);
    wb_read(`TRACE_ADR_PC, data);
    check_eq({tag, " pc"}, pc, data);
    wb_read(`TRACE_ADR_VALUE, data);
    check_eq({tag, " value"}, value, data);
    wb_read(`TRACE_ADR_INFO, data);
    check_eq({tag, " info"}, info, {16'b0, data[15:0]});
    stamp = data[31:16];
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("%s: pass", name);
      tests_passed++;
    end else begin
      $display("%s: fail, %0d check errors", name, err_count - errs_before);
      tests_failed++;
    end
  endtask

  task automatic test_reset();
    logic [31:0] data;
    int          errs;
    errs = err_count;
    wb_read(`TRACE_ADR_STATUS, data);
    check_eq("status", 32'b0, data);
    wb_read(`TRACE_ADR_PC, data);
    check_eq("empty pc", 32'b0, data);
    wb_read(`TRACE_ADR_VALUE, data);
    check_eq("empty value", 32'b0, data);
    wb_read(`TRACE_ADR_INFO, data);
    check_eq("empty info", 32'b0, data);
    wb_read(`TRACE_ADR_STATUS, data);
    check_eq("status", 32'b0, data);
    report_test("reset", errs);
  endtask

  task automatic test_alu();
    logic [31:0] pc [6];
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [4:0]  shamt;
    logic [19:0] uimm;
    logic [15:0] stamp;
    int          errs;
    errs = err_count;
    foreach (pc[n]) pc[n] = $urandom & 32'hffff_fffc;
    rd    = 5'($urandom_range(1, 31));
    rs1   = 5'($urandom);
    rs2   = 5'($urandom);
    imm   = 12'($urandom);
    shamt = 5'($urandom);
    uimm  = 20'($urandom);
    retire(enc_i(imm, rs1, 3'b000, rd, OP_IMM), pc[0]);
    retire(enc_i({7'b0, shamt}, rs1, 3'b001, rd, OP_IMM), pc[1]);
    retire(enc_r(7'b0, rs2, rs1, 3'b000, 5'd0, OP_REG), pc[2]);
    retire(enc_r(7'b0000001, rs2, rs1, 3'b000, rd, OP_REG), pc[3]);
    retire({uimm, rd, OP_LUI}, pc[4]);
    retire({uimm, rd, OP_AUIPC}, pc[5]);
    wait_pipeline();
    check_record("addi", pc[0], sext12(imm), C_OP_IMM, A_RS1 | A_RD, rd, stamp);
    check_record("slli", pc[1], {27'b0, shamt}, C_OP_IMM, A_RS1 | A_RD, rd, stamp);
    // Destination x0 drops the rd bit
    check_record("add", pc[2], 32'b0, C_OP, A_RS1 | A_RS2, 5'd0, stamp);
    check_record("mul", pc[3], 32'b0, C_MULDIV, A_RS1 | A_RS2 | A_RD, rd, stamp);
    check_record("lui", pc[4], {uimm, 12'b0}, C_LUI, A_RD, rd, stamp);
    check_record("auipc", pc[5], {uimm, 12'b0}, C_AUIPC, A_RD, rd, stamp);
    report_test("alu", errs);
  endtask

  task automatic test_control();
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [12:0] off_neg;
    logic [12:0] off_pos;
    logic [20:0] off_j;
    logic [11:0] imm_jalr;
    logic [11:0] imm_st;
    logic [15:0] stamp;
    int          errs;
    errs     = err_count;
    pc       = $urandom & 32'hffff_fffc;
    rd       = 5'($urandom_range(1, 31));
    rs1      = 5'($urandom);
    rs2      = 5'($urandom);
    off_neg  = 13'h1fc0;
    off_pos  = {1'b0, 11'($urandom), 1'b0};
    off_j    = {1'b1, 19'($urandom), 1'b0};
    imm_jalr = 12'($urandom);
    imm_st   = 12'($urandom);
    retire(enc_b(off_neg, rs2, rs1, 3'b000), pc);
    retire(enc_b(off_pos, rs2, rs1, 3'b001), pc + 32'd4);
    retire(enc_j(off_j, rd), pc + 32'd8);
    retire(enc_i(imm_jalr, rs1, 3'b000, rd, OP_JALR), pc + 32'd12);
    retire(enc_i(12'hff8, rs1, 3'b010, rd, OP_LOAD), pc + 32'd16);
    retire(enc_s(imm_st, rs2, rs1, 3'b010), pc + 32'd20);
    wait_pipeline();
    check_record("beq", pc, pc + {{19{off_neg[12]}}, off_neg}, C_BRANCH, A_RS1 | A_RS2,
                 5'd0, stamp);
    check_record("bne", pc + 32'd4, pc + 32'd4 + {19'b0, off_pos}, C_BRANCH,
                 A_RS1 | A_RS2, 5'd0, stamp);
    check_record("jal", pc + 32'd8, pc + 32'd8 + {{11{off_j[20]}}, off_j}, C_JAL, A_RD,
                 rd, stamp);
    check_record("jalr", pc + 32'd12, sext12(imm_jalr), C_JALR, A_RS1 | A_RD, rd, stamp);
    check_record("lw", pc + 32'd16, 32'hffff_fff8, C_LOAD, A_RS1 | A_RD | A_MEM, rd, stamp);
    check_record("sw", pc + 32'd20, sext12(imm_st), C_STORE, A_RS1 | A_RS2 | A_MEM, 5'd0,
                 stamp);
    report_test("control", errs);
  endtask

  task automatic test_system();
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] csr;
    logic [3:0]  pred;
    logic [3:0]  succ;
    logic [15:0] stamp;
    int          errs;
    errs = err_count;
    pc   = $urandom & 32'hffff_fffc;
    rd   = 5'($urandom_range(1, 31));
    rs1  = 5'($urandom);
    csr  = 12'($urandom);
    pred = 4'($urandom);
    succ = 4'($urandom);
    retire(enc_i(csr, rs1, 3'b001, rd, OP_SYSTEM), pc);
    retire(enc_i(csr, rs1, 3'b101, rd, OP_SYSTEM), pc + 32'd4);
    retire(enc_i({4'b0, pred, succ}, 5'd0, 3'b000, 5'd0, OP_FENCE), pc + 32'd8);
    retire(enc_r(7'($urandom), 5'($urandom), rs1, 3'b000, rd, OP_CUSTOM), pc + 32'd12);
    // Low two bits 01 mark a compressed word
    retire({30'($urandom >> 2), 2'b01}, pc + 32'd16);
    wait_pipeline();
    check_record("csrrw", pc, {20'b0, csr}, C_CSR, A_RS1 | A_RD, rd, stamp);
    check_record("csrrwi", pc + 32'd4, {20'b0, csr}, C_CSR, A_RD, rd, stamp);
    check_record("fence", pc + 32'd8, {24'b0, pred, succ}, C_FENCE, 4'b0, 5'd0, stamp);
    check_record("unknown", pc + 32'd12, 32'b0, C_INVAL, 4'b0, 5'd0, stamp);
    check_record("compressed", pc + 32'd16, 32'b0, C_COMPR, 4'b0, 5'd0, stamp);
    report_test("system", errs);
  endtask

  task automatic test_overflow();
    logic [31:0] pc;
    logic [31:0] data;
    logic [31:0] full_status;
    logic [4:0]  rd;
    logic [15:0] stamp;
    int          errs;
    errs        = err_count;
    pc          = $urandom & 32'hffff_fffc;
    rd          = 5'($urandom_range(1, 31));
    full_status = 32'(`TRACE_DEPTH) << `TRACE_STATUS_CNT_LSB;
    full_status[`TRACE_STATUS_OVF_BIT] = 1'b1;
    for (int n = 0; n <= `TRACE_DEPTH; n++) begin
      retire(enc_i(12'(n), 5'd1, 3'b000, rd, OP_IMM), pc + 32'(4 * n));
    end
    wait_pipeline();
    wb_read(`TRACE_ADR_STATUS, data);
    check_eq("status full", full_status, data);
    wb_write(`TRACE_ADR_STATUS, $urandom);
    wb_read(`TRACE_ADR_STATUS, data);
    check_eq("status cleared", 32'(`TRACE_DEPTH) << `TRACE_STATUS_CNT_LSB, data);
    for (int n = 0; n < `TRACE_DEPTH; n++) begin
      check_record($sformatf("record %0d", n), pc + 32'(4 * n), 32'(n), C_OP_IMM,
                   A_RS1 | A_RD, rd, stamp);
    end
    wb_read(`TRACE_ADR_STATUS, data);
    check_eq("status drained", 32'b0, data);
    report_test("overflow", errs);
  endtask

  task automatic test_stamp();
    logic [31:0] pc;
    logic [31:0] insn;
    logic [15:0] stamp_a;
    logic [15:0] stamp_b;
    int          gap;
    int          errs;
    errs = err_count;
    pc   = $urandom & 32'hffff_fffc;
    insn = enc_i(12'h001, 5'd2, 3'b000, 5'd3, OP_IMM);
    gap  = $urandom_range(2, 40);
    retire(insn, pc);
    repeat (gap - 2) @(posedge clk_i);
    retire(insn, pc + 32'd4);
    wait_pipeline();
    check_record("first", pc, 32'd1, C_OP_IMM, A_RS1 | A_RD, 5'd3, stamp_a);
    check_record("second", pc + 32'd4, 32'd1, C_OP_IMM, A_RS1 | A_RD, 5'd3, stamp_b);
    check_eq("stamp delta", 32'(gap), {16'b0, stamp_b - stamp_a});
    report_test("stamp", errs);
  endtask

  initial begin
    rst_ni        = 1'b0;
    rvfi_valid    = 1'b0;
    rvfi_insn     = '0;
    rvfi_pc_rdata = '0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    cycles        = 0;
    err_count     = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    seed_word     = $urandom(SEED);
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_reset();
    test_alu();
    test_control();
    test_system();
    test_overflow();
    test_stamp();

    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: rvfi_trace_assertions.sv
/*
 * Trace unit protocol checks
 * Wishbone ack behavior and FIFO count bound, bound into the top level
 */
`timescale 1ns/1ps
`include "trace_defines.svh"

module rvfi_trace_assertions (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic                             wb_cyc,
  input logic                             wb_stb,
  input logic                             wb_ack,
  input logic [$clog2(`TRACE_DEPTH):0]    count
);

  // Ack only answers a request seen on the previous edge
  ack_after_request: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb)
  ) else $error("wb_ack rose without a preceding request");

  ack_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_ack |=> !wb_ack
  ) else $error("wb_ack high for two consecutive cycles");

  count_bounded: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count <= `TRACE_DEPTH
  ) else $error("FIFO count above depth");

endmodule

bind rvfi_trace_top rvfi_trace_assertions rvfi_trace_assertions_i (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .count  (trace_buffer_i.count_q)
);

// File: rvfi_trace_top.sv
/*
 * Retirement trace unit
 * Capture, decode and buffer of retired instructions with Wishbone read-out
 */
`timescale 1ns/1ps

module rvfi_trace_top (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Core retirement port
  input  logic        rvfi_valid,
  input  logic [31:0] rvfi_insn,
  input  logic [31:0] rvfi_pc_rdata,

  // Wishbone classic slave
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  retire_if ret_if ();

  logic                  rec_valid;
  trace_pkg::trace_rec_t rec;

  retire_capture retire_capture_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rvfi_valid    (rvfi_valid),
    .rvfi_insn     (rvfi_insn),
    .rvfi_pc_rdata (rvfi_pc_rdata),
    .ret           (ret_if.capture)
  );

  insn_decoder insn_decoder_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .ret       (ret_if.decoder),
    .rec_valid (rec_valid),
    .rec       (rec)
  );

  trace_buffer trace_buffer_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rec_valid (rec_valid),
    .rec       (rec),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack)
  );

endmodule

// File: trace_buffer.sv
/*
 * Trace record buffer
 * Record FIFO with sticky overflow, read out through a Wishbone classic slave
 */
`timescale 1ns/1ps
`include "trace_defines.svh"

module trace_buffer (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  rec_valid,
  input  trace_pkg::trace_rec_t rec,

  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [1:0]            wb_adr,
  input  logic [31:0]           wb_dat_w,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack
);

  // Depth is a power of two so the pointers wrap on their own
  localparam int PTR_W = $clog2(`TRACE_DEPTH);

  trace_pkg::trace_rec_t mem [`TRACE_DEPTH];
  trace_pkg::trace_rec_t head;
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [PTR_W:0]        count_q;
  logic                  overflow_q;
  logic                  ack_q;
  logic [31:0]           dat_r_q;
  logic                  wb_req;
  logic                  wr_status;
  logic                  empty;
  logic                  full;
  logic                  push;
  logic                  pop;
  logic                  drop;
  logic [31:0]           status_word;
  logic [31:0]           info_word;
  logic [31:0]           rd_data;

  // A new request is not taken while its ack is still out
  assign wb_req    = wb_cyc & wb_stb & ~ack_q;
  // Any write to status clears overflow
  assign wr_status = wb_req & wb_we & (wb_adr == `TRACE_ADR_STATUS);

  assign empty = (count_q == '0);
  assign full  = (count_q == (PTR_W + 1)'(`TRACE_DEPTH));
  assign pop   = wb_req & ~wb_we & (wb_adr == `TRACE_ADR_INFO) & ~empty;
  assign push  = rec_valid & (~full | pop);
  assign drop  = rec_valid & full & ~pop;
  assign head  = mem[rd_ptr_q];

  always_comb begin
    status_word = '0;
    status_word[`TRACE_STATUS_CNT_LSB +: PTR_W + 1] = count_q;
    status_word[`TRACE_STATUS_OVF_BIT] = overflow_q;

    info_word = '0;
    info_word[`TRACE_INFO_STAMP_LSB +: `TRACE_STAMP_W]   = head.stamp;
    info_word[`TRACE_INFO_CLASS_LSB +: $bits(head.cls)]  = head.cls;
    info_word[`TRACE_INFO_ACCESS_LSB +: $bits(head.access)] = head.access;
    info_word[`TRACE_INFO_RD_LSB +: $bits(head.rd)]      = head.rd;

    case (wb_adr)
      `TRACE_ADR_STATUS: rd_data = status_word;
      `TRACE_ADR_PC:     rd_data = empty ? 32'b0 : head.pc;
      `TRACE_ADR_VALUE:  rd_data = empty ? 32'b0 : head.value;
      `TRACE_ADR_INFO:   rd_data = empty ? 32'b0 : info_word;
      default:           rd_data = 32'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      dat_r_q    <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      ack_q <= wb_req;
      // Head is latched on the same edge that pops it
      if (wb_req) begin
        dat_r_q <= wb_we ? 32'b0 : rd_data;
      end
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // A fresh drop wins over a clear in the same cycle
      if (drop) begin
        overflow_q <= 1'b1;
      end else if (wr_status) begin
        overflow_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= rec;
    end
  end

  assign wb_ack   = ack_q;
  assign wb_dat_r = dat_r_q;

endmodule

// File: insn_decoder.sv
/*
 * Instruction decoder
 * Turns a captured retirement into a trace record in one registered cycle
 */
`timescale 1ns/1ps

module insn_decoder (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  retire_if.decoder             ret,

  output logic                  rec_valid,
  output trace_pkg::trace_rec_t rec
);

  rv_isa_pkg::insn_t      insn;
  logic [31:0]            imm_i;
  logic [31:0]            imm_s;
  logic [31:0]            imm_b;
  logic [31:0]            imm_u;
  logic [31:0]            imm_j;
  trace_pkg::insn_class_e cls;
  trace_pkg::access_t     access;
  logic [31:0]            value;
  logic [4:0]             rd;

  assign insn = ret.insn;

  // Sign-extended immediates of each format
  assign imm_i = {{20{insn.i.imm_11_0[11]}}, insn.i.imm_11_0};
  assign imm_s = {{20{insn.s.imm_11_5[6]}}, insn.s.imm_11_5, insn.s.imm_4_0};
  assign imm_b = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm_31_12, 12'b0};
  assign imm_j = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                  insn.j.imm_11, insn.j.imm_10_1, 1'b0};

  always_comb begin
    cls    = trace_pkg::CLS_INVALID;
    access = '0;
    value  = '0;
    if (insn.r.opcode[1:0] != 2'b11) begin
      cls = trace_pkg::CLS_COMPRESSED;
    end else begin
      case (insn.r.opcode)
        rv_isa_pkg::OPC_LUI: begin
          cls       = trace_pkg::CLS_LUI;
          access.rd = 1'b1;
          value     = imm_u;
        end
        rv_isa_pkg::OPC_AUIPC: begin
          cls       = trace_pkg::CLS_AUIPC;
          access.rd = 1'b1;
          value     = imm_u;
        end
        rv_isa_pkg::OPC_JAL: begin
          cls       = trace_pkg::CLS_JAL;
          access.rd = 1'b1;
          value     = ret.pc + imm_j;
        end
        rv_isa_pkg::OPC_JALR: begin
          if (insn.i.funct3 == 3'b000) begin
            cls    = trace_pkg::CLS_JALR;
            access = '{mem: 1'b0, rd: 1'b1, rs2: 1'b0, rs1: 1'b1};
            value  = imm_i;
          end
        end
        rv_isa_pkg::OPC_BRANCH: begin
          // funct3 010 and 011 are not branches
          if (insn.b.funct3[2:1] != 2'b01) begin
            cls    = trace_pkg::CLS_BRANCH;
            access = '{mem: 1'b0, rd: 1'b0, rs2: 1'b1, rs1: 1'b1};
            value  = ret.pc + imm_b;
          end
        end
        rv_isa_pkg::OPC_LOAD: begin
          if (insn.i.funct3 != 3'b011 && insn.i.funct3[2:1] != 2'b11) begin
            cls    = trace_pkg::CLS_LOAD;
            access = '{mem: 1'b1, rd: 1'b1, rs2: 1'b0, rs1: 1'b1};
            value  = imm_i;
          end
        end
        rv_isa_pkg::OPC_STORE: begin
          if (insn.s.funct3[2] == 1'b0 && insn.s.funct3 != 3'b011) begin
            cls    = trace_pkg::CLS_STORE;
            access = '{mem: 1'b1, rd: 1'b0, rs2: 1'b1, rs1: 1'b1};
            value  = imm_s;
          end
        end
        rv_isa_pkg::OPC_OP_IMM: begin
          if (insn.r.funct3[1:0] == 2'b01) begin
            // Shift amount sits in the rs2 field
            if (insn.r.funct7 == 7'b0000000 ||
                (insn.r.funct3 == 3'b101 && insn.r.funct7 == rv_isa_pkg::FUNCT7_ALT)) begin
              cls    = trace_pkg::CLS_OP_IMM;
              access = '{mem: 1'b0, rd: 1'b1, rs2: 1'b0, rs1: 1'b1};
              value  = {27'b0, insn.r.rs2};
            end
          end else begin
            cls    = trace_pkg::CLS_OP_IMM;
            access = '{mem: 1'b0, rd: 1'b1, rs2: 1'b0, rs1: 1'b1};
            value  = imm_i;
          end
        end
        rv_isa_pkg::OPC_OP: begin
          if (insn.r.funct7 == rv_isa_pkg::FUNCT7_MULDIV) begin
            cls    = trace_pkg::CLS_MULDIV;
            access = '{mem: 1'b0, rd: 1'b1, rs2: 1'b1, rs1: 1'b1};
          end else if (insn.r.funct7 == 7'b0000000 ||
                       (insn.r.funct7 == rv_isa_pkg::FUNCT7_ALT &&
                        (insn.r.funct3 == 3'b000 || insn.r.funct3 == 3'b101))) begin
            cls    = trace_pkg::CLS_OP;
            access = '{mem: 1'b0, rd: 1'b1, rs2: 1'b1, rs1: 1'b1};
          end
        end
        rv_isa_pkg::OPC_MISC_MEM: begin
          // fence and fence.i, pred and succ nibbles land in value[7:0]
          if (insn.i.funct3[2:1] == 2'b00) begin
            cls   = trace_pkg::CLS_FENCE;
            value = {24'b0, insn.i.imm_11_0[7:0]};
          end
        end
        rv_isa_pkg::OPC_SYSTEM: begin
          if (insn.i.funct3 == 3'b000) begin
            cls = trace_pkg::CLS_SYSTEM;
          end else if (insn.i.funct3 != 3'b100) begin
            cls        = trace_pkg::CLS_CSR;
            access.rd  = 1'b1;
            // Immediate forms put a zimm in the rs1 field
            access.rs1 = ~insn.i.funct3[2];
            value      = {20'b0, insn.i.imm_11_0};
          end
        end
        default: begin
          cls = trace_pkg::CLS_INVALID;
        end
      endcase
    end

    // Writes to x0 are discarded by the core
    if (insn.r.rd == 5'd0) begin
      access.rd = 1'b0;
    end
  end

  // rd reported only when the instruction writes a register
  assign rd = access.rd ? insn.r.rd : 5'd0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_valid <= 1'b0;
    end else begin
      rec_valid <= ret.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ret.valid) begin
      rec <= '{pc: ret.pc, value: value, stamp: ret.stamp, cls: cls,
               access: access, rd: rd};
    end
  end

endmodule

// File: retire_capture.sv
/*
 * Retirement capture
 * Registers valid retirements from the core and stamps them with the cycle count
 */
`timescale 1ns/1ps
`include "trace_defines.svh"

module retire_capture (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        rvfi_valid,
  input  logic [31:0] rvfi_insn,
  input  logic [31:0] rvfi_pc_rdata,

  retire_if.capture   ret
);

  // Free-running cycle count since reset, wraps at the stamp width
  logic [`TRACE_STAMP_W-1:0] cycle_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q   <= '0;
      ret.valid <= 1'b0;
    end else begin
      cycle_q   <= cycle_q + 1'b1;
      ret.valid <= rvfi_valid;
    end
  end

  // Stamp is the count seen at the sampling edge
  always_ff @(posedge clk_i) begin
    if (rvfi_valid) begin
      ret.insn  <= rv_isa_pkg::insn_t'(rvfi_insn);
      ret.pc    <= rvfi_pc_rdata;
      ret.stamp <= cycle_q;
    end
  end

endmodule

// File: retire_if.sv
/*
 * Captured retirement
 * Carries one sampled instruction with its PC and cycle stamp to the decoder
 */
`timescale 1ns/1ps
`include "trace_defines.svh"

interface retire_if;

  logic                      valid;
  rv_isa_pkg::insn_t         insn;
  logic [31:0]               pc;
  logic [`TRACE_STAMP_W-1:0] stamp;

  modport capture (
    output valid,
    output insn,
    output pc,
    output stamp
  );

  modport decoder (
    input valid,
    input insn,
    input pc,
    input stamp
  );

endinterface

// File: trace_pkg.sv
/*
 * Trace record types
 * Instruction classes, operand access mask and the record kept in the FIFO
 */
`include "trace_defines.svh"

package trace_pkg;

  typedef enum logic [3:0] {
    CLS_LUI        = 4'd0,
    CLS_AUIPC      = 4'd1,
    CLS_JAL        = 4'd2,
    CLS_JALR       = 4'd3,
    CLS_BRANCH     = 4'd4,
    CLS_LOAD       = 4'd5,
    CLS_STORE      = 4'd6,
    CLS_OP_IMM     = 4'd7,
    CLS_OP         = 4'd8,
    CLS_MULDIV     = 4'd9,
    CLS_CSR        = 4'd10,
    CLS_FENCE      = 4'd11,
    CLS_SYSTEM     = 4'd12,
    CLS_COMPRESSED = 4'd13,
    CLS_INVALID    = 4'd14
  } insn_class_e;

  // Bit 0 is rs1, bit 3 is memory
  typedef struct packed {
    logic mem;
    logic rd;
    logic rs2;
    logic rs1;
  } access_t;

  typedef struct packed {
    logic [31:0]               pc;
    logic [31:0]               value;
    logic [`TRACE_STAMP_W-1:0] stamp;
    insn_class_e               cls;
    access_t                   access;
    logic [4:0]                rd;
  } trace_rec_t;

endpackage

// File: rv_isa_pkg.sv
/*
 * RV32 instruction set encodings
 * Opcode and funct constants, and the base instruction formats as one union
 */
package rv_isa_pkg;

  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // M extension, and the alternate encoding used by sub and sra
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // Branch offset bits are scattered around the register fields
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    logic [31:0] raw;
    r_fmt_t      r;
    i_fmt_t      i;
    s_fmt_t      s;
    b_fmt_t      b;
    u_fmt_t      u;
    j_fmt_t      j;
  } insn_t;

endpackage

// File: trace_defines.svh
/*
 * Retirement trace unit parameters
 * Record FIFO size, stamp width, Wishbone register map and word layouts
 */
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

// Record FIFO
`define TRACE_DEPTH   8
`define TRACE_STAMP_W 16

// Wishbone word addresses
`define TRACE_ADR_STATUS 2'd0
`define TRACE_ADR_PC     2'd1
`define TRACE_ADR_VALUE  2'd2
`define TRACE_ADR_INFO   2'd3

// Info word: stamp, class, access mask, rd, low three bits zero
`define TRACE_INFO_STAMP_LSB  16
`define TRACE_INFO_CLASS_LSB  12
`define TRACE_INFO_ACCESS_LSB 8
`define TRACE_INFO_RD_LSB     3

// Status word
// Record count starts at bit 0
`define TRACE_STATUS_CNT_LSB 0
`define TRACE_STATUS_OVF_BIT 31

`endif
